// File: source/vid_pkg.sv
/* Video stream definitions: channel and sync widths, sync nibble layout,
   Rec. 601 fixed-point weights, converter latency and the colour space enum */
package vid_pkg;

  ////////////////////////////////////////////////////////////
  // Stream widths
  ////////////////////////////////////////////////////////////
  localparam int color_w = 8;
  localparam int sync_w  = 4;

  // Sync nibble layout, every bit active low
  localparam int vs_bit    = 3;
  localparam int clamp_bit = 2;
  localparam int hs_bit    = 1;
  localparam int cs_bit    = 0;

  ////////////////////////////////////////////////////////////
  // Rec. 601 weights scaled by 2^20
  ////////////////////////////////////////////////////////////
  localparam int coeff_w = 20;

  // Luma weights, they sum to exactly 2^20
  localparam logic [coeff_w-1:0] coef_yr  = 20'd313524;
  localparam logic [coeff_w-1:0] coef_yg  = 20'd615514;
  localparam logic [coeff_w-1:0] coef_yb  = 20'd119538;
  // Negative part of Pb, normalized so B carries unit weight
  localparam logic [coeff_w-1:0] coef_pbr = 20'd353865;
  localparam logic [coeff_w-1:0] coef_pbg = 20'd694711;
  // Negative part of Pr, normalized so R carries unit weight
  localparam logic [coeff_w-1:0] coef_prg = 20'd878052;
  localparam logic [coeff_w-1:0] coef_prb = 20'd170524;

  // Converter depth in YPbPr mode
  localparam int conv_lat = 4;

  typedef enum logic {MODE_RGB = 1'b0, MODE_YPBPR = 1'b1} vid_mode_e;

endpackage

// File: source/cfg_pkg.sv
/* Configuration space: register address map, field positions and reset values */
package cfg_pkg;

  // Bus widths
  localparam int cfg_addr_w = 2;
  localparam int cfg_data_w = 8;

  // Register map, addresses 2 and 3 are unused
  typedef enum logic [cfg_addr_w-1:0] {
    REG_MODE = 2'd0,
    REG_SYNC = 2'd1
  } cfg_reg_e;

  // Field positions
  localparam int mode_bit  = 0;
  localparam int sog_bit   = 0;
  localparam int blank_bit = 1;

  // Values after reset
  localparam vid_pkg::vid_mode_e mode_rst = vid_pkg::MODE_RGB;
  localparam logic sog_rst   = 1'b0;
  localparam logic blank_rst = 1'b1;

endpackage

// File: source/cfg_regs.sv
/* Configuration registers for colour space and sync options,
   with write strobe and combinational read-back */
`timescale 1ns/1ns

module cfg_regs (
  input  logic                           VCLK,
  input  logic                           nRST,
  input  logic                           cfg_we_i,
  input  logic [cfg_pkg::cfg_addr_w-1:0] cfg_addr_i,
  input  logic [cfg_pkg::cfg_data_w-1:0] cfg_wdata_i,
  output logic [cfg_pkg::cfg_data_w-1:0] cfg_rdata_o,
  output vid_pkg::vid_mode_e             mode_o,
  output logic                           sog_o,
  output logic                           blank_en_o
);

  // Address seen through the register map
  cfg_pkg::cfg_reg_e addr;

  assign addr = cfg_pkg::cfg_reg_e'(cfg_addr_i);

  ////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      mode_o     <= cfg_pkg::mode_rst;
      sog_o      <= cfg_pkg::sog_rst;
      blank_en_o <= cfg_pkg::blank_rst;
    end else if (cfg_we_i) begin
      case (addr)
        cfg_pkg::REG_MODE: mode_o <= vid_pkg::vid_mode_e'(cfg_wdata_i[cfg_pkg::mode_bit]);
        cfg_pkg::REG_SYNC: begin
          sog_o      <= cfg_wdata_i[cfg_pkg::sog_bit];
          blank_en_o <= cfg_wdata_i[cfg_pkg::blank_bit];
        end
        // Unused addresses are dropped
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////////////////////////
  always_comb begin
    cfg_rdata_o = '0;
    case (addr)
      cfg_pkg::REG_MODE: cfg_rdata_o[cfg_pkg::mode_bit] = mode_o;
      cfg_pkg::REG_SYNC: begin
        cfg_rdata_o[cfg_pkg::sog_bit]   = sog_o;
        cfg_rdata_o[cfg_pkg::blank_bit] = blank_en_o;
      end
      default: ;
    endcase
  end

  // An unknown address under the strobe would corrupt an arbitrary control bit
  a_wr_addr_known: assert property (@(posedge VCLK) disable iff (!nRST)
    cfg_we_i |-> !$isunknown(cfg_addr_i));

endmodule

// File: source/vconv.sv
/* RGB to YPbPr conversion after Rec. 601, four stage pipeline
   with single register bypass for RGB and the sync nibble carried along */
`timescale 1ns/1ns

module vconv (
  input  logic                         VCLK,
  input  logic                         nRST,
  input  vid_pkg::vid_mode_e           mode_i,
  input  logic [vid_pkg::sync_w-1:0]   sync_i,
  input  logic [vid_pkg::color_w-1:0]  r_i,
  input  logic [vid_pkg::color_w-1:0]  g_i,
  input  logic [vid_pkg::color_w-1:0]  b_i,
  output logic [vid_pkg::sync_w-1:0]   sync_o,
  output logic [vid_pkg::color_w-1:0]  v1_o,
  output logic [vid_pkg::color_w-1:0]  v2_o,
  output logic [vid_pkg::color_w-1:0]  v3_o
);

  // Sync and colour delay line
  logic [vid_pkg::sync_w-1:0]  s_d1, s_d2, s_d3;
  logic [vid_pkg::color_w-1:0] r_d1, g_d1, b_d1;
  logic [vid_pkg::color_w-1:0] r_d2, b_d2, r_d3, b_d3;

  // Scaled products
  logic [vid_pkg::color_w+vid_pkg::coeff_w-1:0] yr_p, yg_p, yb_p;
  logic [vid_pkg::color_w+vid_pkg::coeff_w-1:0] pbr_p, pbg_p, prg_p, prb_p;

  // Sums, Y with two guard bits and the chroma negative parts with one
  logic [vid_pkg::color_w+vid_pkg::coeff_w+1:0] y_sum;
  logic [vid_pkg::color_w+vid_pkg::coeff_w:0]   pb_nsum, pr_nsum;

  // Chroma before rounding, twice the signed result
  logic signed [vid_pkg::color_w+vid_pkg::coeff_w+1:0] pb_diff, pr_diff;
  logic [vid_pkg::color_w-1:0] y_rnd;

  // Round at the top fraction bit, clip at +127 and move to midscale
  function automatic logic [vid_pkg::color_w-1:0] chroma_out(
    input logic signed [vid_pkg::color_w+vid_pkg::coeff_w+1:0] diff
  );
    logic signed [vid_pkg::color_w+1:0] rnd;
    rnd = $signed(diff[vid_pkg::color_w+vid_pkg::coeff_w+1:vid_pkg::coeff_w+1]) +
          $signed({{(vid_pkg::color_w+1){1'b0}}, diff[vid_pkg::coeff_w]});
    // Pure blue or red lands at +127.5 and would wrap
    if (rnd > 10'sd127) begin
      rnd = 10'sd127;
    end
    // Two's complement to offset binary
    return {~rnd[vid_pkg::color_w-1], rnd[vid_pkg::color_w-2:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage 1, input delay
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK) begin
    s_d1 <= sync_i;
    r_d1 <= r_i;
    g_d1 <= g_i;
    b_d1 <= b_i;
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, products
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK) begin
    yr_p  <= vid_pkg::coef_yr * r_d1;
    yg_p  <= vid_pkg::coef_yg * g_d1;
    yb_p  <= vid_pkg::coef_yb * b_d1;
    pbr_p <= vid_pkg::coef_pbr * r_d1;
    pbg_p <= vid_pkg::coef_pbg * g_d1;
    prg_p <= vid_pkg::coef_prg * g_d1;
    prb_p <= vid_pkg::coef_prb * b_d1;
    // R and B travel on for the unit weighted chroma term
    s_d2  <= s_d1;
    r_d2  <= r_d1;
    b_d2  <= b_d1;
  end

  ////////////////////////////////////////////////////////////
  // Stage 3, sums
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK) begin
    y_sum   <= yr_p + yg_p + yb_p;
    pb_nsum <= pbr_p + pbg_p;
    pr_nsum <= prg_p + prb_p;
    s_d3    <= s_d2;
    r_d3    <= r_d2;
    b_d3    <= b_d2;
  end

  // Pb = (B - nsum) / 2 and Pr = (R - nsum) / 2, the halving is in the bit pick
  assign pb_diff = $signed({2'b00, b_d3, {vid_pkg::coeff_w{1'b0}}}) - $signed({1'b0, pb_nsum});
  assign pr_diff = $signed({2'b00, r_d3, {vid_pkg::coeff_w{1'b0}}}) - $signed({1'b0, pr_nsum});

  // Y never exceeds 255.0 since the weights sum to one
  assign y_rnd = y_sum[vid_pkg::color_w+vid_pkg::coeff_w-1:vid_pkg::coeff_w] +
                 vid_pkg::color_w'(y_sum[vid_pkg::coeff_w-1]);

  ////////////////////////////////////////////////////////////
  // Stage 4, output register and bypass
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      sync_o <= '0;
      v2_o   <= '0;
      // Chroma rests at midscale in YPbPr
      if (mode_i == vid_pkg::MODE_YPBPR) begin
        v1_o <= {1'b1, {(vid_pkg::color_w-1){1'b0}}};
        v3_o <= {1'b1, {(vid_pkg::color_w-1){1'b0}}};
      end else begin
        v1_o <= '0;
        v3_o <= '0;
      end
    end else if (mode_i == vid_pkg::MODE_YPBPR) begin
      sync_o <= s_d3;
      v1_o   <= chroma_out(pr_diff);
      v2_o   <= y_rnd;
      v3_o   <= chroma_out(pb_diff);
    end else begin
      sync_o <= sync_i;
      v1_o   <= r_i;
      v2_o   <= g_i;
      v3_o   <= b_i;
    end
  end

  // Sync stays aligned with the pixel through the whole pipeline
  a_sync_aligned: assert property (@(posedge VCLK) disable iff (!nRST)
    (mode_i == vid_pkg::MODE_YPBPR) [*vid_pkg::conv_lat] |=>
      sync_o == $past(sync_i, vid_pkg::conv_lat));

endmodule

// File: source/dac_drive.sv
/* DAC output register with blanking levels, sync-on-green and H/V sync pins */
`timescale 1ns/1ns

module dac_drive (
  input  logic                        VCLK,
  input  logic                        nRST,
  input  vid_pkg::vid_mode_e          mode_i,
  input  logic                        sog_i,
  input  logic                        blank_en_i,
  input  logic [vid_pkg::sync_w-1:0]  sync_i,
  input  logic [vid_pkg::color_w-1:0] v1_i,
  input  logic [vid_pkg::color_w-1:0] v2_i,
  input  logic [vid_pkg::color_w-1:0] v3_i,
  output logic [vid_pkg::color_w-1:0] dac_v1_o,
  output logic [vid_pkg::color_w-1:0] dac_v2_o,
  output logic [vid_pkg::color_w-1:0] dac_v3_o,
  output logic                        dac_nsync_o,
  output logic                        dac_nblank_o,
  output logic                        hsync_o,
  output logic                        vsync_o
);

  // Pixel falls in horizontal or vertical blanking
  logic                        blank_now;
  // Blank level of the chroma channels
  logic [vid_pkg::color_w-1:0] chroma_blank;

  assign blank_now = blank_en_i &
                     (~sync_i[vid_pkg::hs_bit] | ~sync_i[vid_pkg::vs_bit]);

  // Offset binary zero in YPbPr, black in RGB
  assign chroma_blank = (mode_i == vid_pkg::MODE_YPBPR) ?
                        {1'b1, {(vid_pkg::color_w-1){1'b0}}} : '0;

  ////////////////////////////////////////////////////////////
  // Colour channels
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK) begin
    if (blank_now) begin
      dac_v1_o <= chroma_blank;
      dac_v2_o <= '0;
      dac_v3_o <= chroma_blank;
    end else begin
      dac_v1_o <= v1_i;
      dac_v2_o <= v2_i;
      dac_v3_o <= v3_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control pins
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      dac_nblank_o <= 1'b0;
      dac_nsync_o  <= 1'b1;
      hsync_o      <= 1'b1;
      vsync_o      <= 1'b1;
    end else begin
      dac_nblank_o <= ~blank_now;
      // Composite sync goes to the DAC only for sync-on-green
      dac_nsync_o  <= sog_i ? sync_i[vid_pkg::cs_bit] : 1'b1;
      hsync_o      <= sync_i[vid_pkg::hs_bit];
      vsync_o      <= sync_i[vid_pkg::vs_bit];
    end
  end

  // With blanking disabled the DAC never sees a blank
  a_no_blank: assert property (@(posedge VCLK) disable iff (!nRST)
    !blank_en_i |=> dac_nblank_o);

endmodule

// File: source/vout_top.sv
/* Video output stage top: config registers, colour converter and DAC driver */
`timescale 1ns/1ns

module vout_top (
  input  logic                           VCLK,
  input  logic                           nRST,
  // Configuration bus
  input  logic                           cfg_we_i,
  input  logic [cfg_pkg::cfg_addr_w-1:0] cfg_addr_i,
  input  logic [cfg_pkg::cfg_data_w-1:0] cfg_wdata_i,
  output logic [cfg_pkg::cfg_data_w-1:0] cfg_rdata_o,
  // Pixel stream
  input  logic [vid_pkg::sync_w-1:0]     vid_sync_i,
  input  logic [vid_pkg::color_w-1:0]    vid_r_i,
  input  logic [vid_pkg::color_w-1:0]    vid_g_i,
  input  logic [vid_pkg::color_w-1:0]    vid_b_i,
  // DAC pins
  output logic [vid_pkg::color_w-1:0]    dac_v1_o,
  output logic [vid_pkg::color_w-1:0]    dac_v2_o,
  output logic [vid_pkg::color_w-1:0]    dac_v3_o,
  output logic                           dac_nsync_o,
  output logic                           dac_nblank_o,
  output logic                           hsync_o,
  output logic                           vsync_o
);

  // Controls from the register block
  vid_pkg::vid_mode_e          mode;
  logic                        sog;
  logic                        blank_en;
  // Converted stream, V1 Pr or R, V2 Y or G, V3 Pb or B
  logic [vid_pkg::sync_w-1:0]  conv_sync;
  logic [vid_pkg::color_w-1:0] conv_v1, conv_v2, conv_v3;

  cfg_regs u_cfg (
    .VCLK        (VCLK),
    .nRST        (nRST),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .mode_o      (mode),
    .sog_o       (sog),
    .blank_en_o  (blank_en)
  );

  vconv u_conv (
    .VCLK   (VCLK),
    .nRST   (nRST),
    .mode_i (mode),
    .sync_i (vid_sync_i),
    .r_i    (vid_r_i),
    .g_i    (vid_g_i),
    .b_i    (vid_b_i),
    .sync_o (conv_sync),
    .v1_o   (conv_v1),
    .v2_o   (conv_v2),
    .v3_o   (conv_v3)
  );

  dac_drive u_dac (
    .VCLK         (VCLK),
    .nRST         (nRST),
    .mode_i       (mode),
    .sog_i        (sog),
    .blank_en_i   (blank_en),
    .sync_i       (conv_sync),
    .v1_i         (conv_v1),
    .v2_i         (conv_v2),
    .v3_i         (conv_v3),
    .dac_v1_o     (dac_v1_o),
    .dac_v2_o     (dac_v2_o),
    .dac_v3_o     (dac_v3_o),
    .dac_nsync_o  (dac_nsync_o),
    .dac_nblank_o (dac_nblank_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o)
  );

endmodule

// File: test/tb_vout_top.sv
/* Directed testbench for the video output stage: register access, RGB bypass,
   YPbPr conversion against a real-valued Rec. 601 model, blanking and sync pins */
`timescale 1ns/1ns

module tb_vout_top;

  localparam int max_px = 64;

  logic                           VCLK;
  logic                           nRST;
  logic                           cfg_we_i;
  logic [cfg_pkg::cfg_addr_w-1:0] cfg_addr_i;
  logic [cfg_pkg::cfg_data_w-1:0] cfg_wdata_i;
  logic [cfg_pkg::cfg_data_w-1:0] cfg_rdata_o;
  logic [3:0] vid_sync_i;
  logic [7:0] vid_r_i, vid_g_i, vid_b_i;
  logic [7:0] dac_v1_o, dac_v2_o, dac_v3_o;
  logic       dac_nsync_o, dac_nblank_o, hsync_o, vsync_o;

  // Configuration as the testbench believes it to be
  vid_pkg::vid_mode_e cur_mode;
  logic               cur_sog;
  logic               cur_blank;

  // Pixel list played into the DUT
  logic [7:0] px_r [0:max_px-1];
  logic [7:0] px_g [0:max_px-1];
  logic [7:0] px_b [0:max_px-1];
  logic [3:0] px_s [0:max_px-1];

  vout_top dut (.*);

  initial VCLK = 1'b0;
  always #4 VCLK = ~VCLK;

  ////////////////////////////////////////////////////////////
  // Reporting and waiting
  ////////////////////////////////////////////////////////////
  task automatic report_error(input string msg);
    $display("Testbench failed");
    $display("Error at time %0t: %s", $time, msg);
    $fatal(1);
  endtask

  // Actual value must lie within tol of the expected one
  task automatic check_near(input int act, input int exp, input int tol, input string what);
    assert ((act - exp <= tol) && (exp - act <= tol)) else
      report_error($sformatf("%s is %0d, expected %0d", what, act, exp));
  endtask

  task automatic wait_nblank(input int limit);
    int n;
    n = 0;
    while (dac_nblank_o !== 1'b1) begin
      if (n == limit) begin
        $display("Testbench failed");
        $display("Timeout: dac_nblank_o stayed low for %0d cycles", limit);
        $fatal(1);
      end
      @(posedge VCLK);
      n++;
    end
  endtask

  // Let the pipeline run through after a mode change
  task automatic settle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge VCLK);
    end
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Configuration bus
  ////////////////////////////////////////////////////////////
  task automatic write_cfg(input logic [cfg_pkg::cfg_addr_w-1:0] addr,
                           input logic [cfg_pkg::cfg_data_w-1:0] data);
    @(posedge VCLK);
    #1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge VCLK);
    #1;
    cfg_we_i = 1'b0;
    // Track the fields, writes elsewhere are lost
    if (addr == cfg_pkg::REG_MODE) begin
      cur_mode = vid_pkg::vid_mode_e'(data[cfg_pkg::mode_bit]);
    end else if (addr == cfg_pkg::REG_SYNC) begin
      cur_sog   = data[cfg_pkg::sog_bit];
      cur_blank = data[cfg_pkg::blank_bit];
    end
  endtask

  // Read-back is combinational
  task automatic read_check(input logic [cfg_pkg::cfg_addr_w-1:0] addr,
                            input logic [cfg_pkg::cfg_data_w-1:0] exp);
    cfg_addr_i = addr;
    #1;
    check_near(cfg_rdata_o, exp, 0, $sformatf("cfg_rdata_o at address %0d", addr));
  endtask

  ////////////////////////////////////////////////////////////
  // Pixel stream and reference model
  ////////////////////////////////////////////////////////////
  function automatic int to_code(input real x);
    if (x < 0.0) x = 0.0;
    if (x > 255.0) x = 255.0;
    return $rtoi(x + 0.5);
  endfunction

  task automatic set_pixel(input int i, input int r, input int g, input int b, input int s);
    px_r[i] = r;
    px_g[i] = g;
    px_b[i] = b;
    px_s[i] = s;
  endtask

  // Random colour, with a random sync nibble or all sync inactive
  task automatic fill_random(input int n, input bit rand_sync);
    for (int i = 0; i < n; i++) begin
      set_pixel(i, $urandom, $urandom, $urandom, rand_sync ? $urandom : 4'hF);
    end
  endtask

  task automatic check_pixel(input int i);
    logic blanked;
    real  y;
    int   e1, e2, e3, tol;
    blanked = cur_blank && (!px_s[i][1] || !px_s[i][3]);
    check_near(dac_nblank_o, !blanked, 0, "dac_nblank_o");
    check_near(hsync_o, px_s[i][1], 0, "hsync_o");
    check_near(vsync_o, px_s[i][3], 0, "vsync_o");
    check_near(dac_nsync_o, cur_sog ? px_s[i][0] : 1'b1, 0, "dac_nsync_o");
    tol = 0;
    if (blanked) begin
      // Black, chroma at its zero level in YPbPr
      e1 = (cur_mode == vid_pkg::MODE_YPBPR) ? 128 : 0;
      e2 = 0;
      e3 = e1;
    end else if (cur_mode == vid_pkg::MODE_RGB) begin
      e1 = px_r[i];
      e2 = px_g[i];
      e3 = px_b[i];
    end else begin
      // Rec. 601 luma, Pb and Pr scaled to +-0.5 and offset by 128
      y   = 0.299 * px_r[i] + 0.587 * px_g[i] + 0.114 * px_b[i];
      e2  = to_code(y);
      e3  = to_code(128.0 + (px_b[i] - y) / 1.772);
      e1  = to_code(128.0 + (px_r[i] - y) / 1.402);
      tol = 1;
    end
    check_near(dac_v1_o, e1, tol, $sformatf("dac_v1_o for pixel %0d", i));
    check_near(dac_v2_o, e2, tol, $sformatf("dac_v2_o for pixel %0d", i));
    check_near(dac_v3_o, e3, tol, $sformatf("dac_v3_o for pixel %0d", i));
  endtask

  // One pixel per cycle, each checked after the latency of the mode
  task automatic play(input int n);
    int lat;
    lat = (cur_mode == vid_pkg::MODE_YPBPR) ? vid_pkg::conv_lat + 1 : 2;
    for (int c = 0; c < n + lat; c++) begin
      @(posedge VCLK);
      #1;
      if (c >= lat) check_pixel(c - lat);
      if (c < n) begin
        vid_r_i    = px_r[c];
        vid_g_i    = px_g[c];
        vid_b_i    = px_b[c];
        vid_sync_i = px_s[c];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset_regs();
    repeat (4) @(posedge VCLK);
    #1;
    check_near(dac_nblank_o, 0, 0, "dac_nblank_o in reset");
    check_near(dac_nsync_o, 1, 0, "dac_nsync_o in reset");
    @(posedge VCLK);
    #1;
    nRST = 1'b1;
    read_check(cfg_pkg::REG_MODE, 8'h00);
    read_check(cfg_pkg::REG_SYNC, 8'h02);
    write_cfg(cfg_pkg::REG_MODE, 8'h01);
    read_check(cfg_pkg::REG_MODE, 8'h01);
    write_cfg(cfg_pkg::REG_SYNC, 8'h01);
    read_check(cfg_pkg::REG_SYNC, 8'h01);
    // Unused address holds nothing and disturbs nothing
    // Every field bit of this pattern differs from the values held now
    write_cfg(2'd2, 8'hFE);
    read_check(2'd2, 8'h00);
    read_check(2'd3, 8'h00);
    read_check(cfg_pkg::REG_MODE, 8'h01);
    read_check(cfg_pkg::REG_SYNC, 8'h01);
    write_cfg(cfg_pkg::REG_MODE, 8'h00);
    write_cfg(cfg_pkg::REG_SYNC, 8'h02);
    wait_nblank(10);
  endtask

  task automatic test_rgb_bypass();
    write_cfg(cfg_pkg::REG_SYNC, 8'h00);
    write_cfg(cfg_pkg::REG_MODE, 8'h00);
    settle(5);
    fill_random(32, 1'b0);
    play(32);
  endtask

  task automatic test_ypbpr();
    write_cfg(cfg_pkg::REG_SYNC, 8'h00);
    write_cfg(cfg_pkg::REG_MODE, 8'h01);
    settle(5);
    fill_random(32, 1'b0);
    play(32);
    // Black, white, primaries and secondaries
    set_pixel(0, 0, 0, 0, 4'hF);
    set_pixel(1, 255, 255, 255, 4'hF);
    set_pixel(2, 255, 0, 0, 4'hF);
    set_pixel(3, 0, 255, 0, 4'hF);
    set_pixel(4, 0, 0, 255, 4'hF);
    set_pixel(5, 255, 255, 0, 4'hF);
    set_pixel(6, 0, 255, 255, 4'hF);
    set_pixel(7, 255, 0, 255, 4'hF);
    play(8);
  endtask

  task automatic test_blanking();
    write_cfg(cfg_pkg::REG_SYNC, 8'h02);
    write_cfg(cfg_pkg::REG_MODE, 8'h00);
    settle(5);
    fill_random(40, 1'b1);
    play(40);
    write_cfg(cfg_pkg::REG_MODE, 8'h01);
    settle(5);
    fill_random(40, 1'b1);
    play(40);
  endtask

  task automatic test_sync_outputs();
    write_cfg(cfg_pkg::REG_MODE, 8'h00);
    write_cfg(cfg_pkg::REG_SYNC, 8'h01);
    settle(5);
    fill_random(40, 1'b1);
    play(40);
    // Sync-on-green off, composite sync must not reach the DAC
    write_cfg(cfg_pkg::REG_SYNC, 8'h00);
    fill_random(40, 1'b1);
    play(40);
  endtask

  initial begin
    nRST        = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    vid_sync_i  = 4'hF;
    vid_r_i     = '0;
    vid_g_i     = '0;
    vid_b_i     = '0;
    cur_mode    = vid_pkg::MODE_RGB;
    cur_sog     = 1'b0;
    cur_blank   = 1'b1;
    void'($urandom(32'h2466));
    test_reset_regs();
    test_rgb_bypass();
    test_ypbpr();
    test_blanking();
    test_sync_outputs();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: vout_top.f
source/vid_pkg.sv
source/cfg_pkg.sv
source/cfg_regs.sv
source/vconv.sv
source/dac_drive.sv
source/vout_top.sv
test/tb_vout_top.sv

// File: Bender.yml
package:
  name: vout_top

sources:
  # Packages first, the config package refers to the video package
  - source/vid_pkg.sv
  - source/cfg_pkg.sv
  # RTL
  - source/cfg_regs.sv
  - source/vconv.sv
  - source/dac_drive.sv
  - source/vout_top.sv
  # Testbench
  - target: test
    files:
      - test/tb_vout_top.sv
